// ==== timerPkg.sv ====
package timerPkg;

  localparam int ResultWidth = 64;  // Width of every returned result

  //////////////////////
  // Command encoding
  //////////////////////

  typedef enum logic [15:0] {
    OpStart = 16'd1,
    OpStop  = 16'd2,
    OpReset = 16'd3,
    OpRead  = 16'd4,
    OpLap   = 16'd5
  } opcodeT;

  typedef struct packed {
    opcodeT      opcode;  // Upper half of the command word
    logic [15:0] arg;     // Lower half, ignored
  } cmdT;

  //////////////////////
  // Control and results
  //////////////////////

  typedef enum logic [1:0] {
    Fetch,
    Decode,
    SendWait
  } seqStateT;

  typedef enum logic {
    SnapRead,
    SnapLap
  } snapKindT;

  // Result split into its two return beats
  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } resultT;

endpackage

// ==== tickCounter.sv ====
`timescale 1ns/1ps

module tickCounter #(
  parameter int Width = 64
) (
  input  logic             ACLK,
  input  logic             ARESETN,
  input  logic             countEnable,
  input  logic             countClear,
  output logic [Width-1:0] count
);

  //////////////////////
  // Time base
  //////////////////////

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      count <= '0;
    end else if (countClear) begin
      count <= '0;  // Clear wins over enable
    end else if (countEnable) begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== lapRecorder.sv ====
`timescale 1ns/1ps

module lapRecorder import timerPkg::*; #(
  parameter int Width = 64
) (
  input  logic                   ACLK,
  input  logic                   ARESETN,
  input  logic [Width-1:0]       count,
  input  logic                   countClear,
  input  logic                   snapStrobe,
  input  snapKindT               snapKind,
  output logic                   resultLoad,
  output logic [ResultWidth-1:0] result
);

  logic [Width-1:0] lapMark;   // Count at the previous lap
  logic [Width-1:0] lapDelta;

  assign lapDelta = count - lapMark;

  //////////////////////
  // Lap mark
  //////////////////////

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      lapMark    <= '0;
      resultLoad <= 1'b0;
    end else begin
      resultLoad <= snapStrobe;  // One cycle after the snapshot edge
      if (countClear) begin
        lapMark <= '0;
      end else if (snapStrobe && (snapKind == SnapLap)) begin
        lapMark <= count;
      end
    end
  end

  //////////////////////
  // Snapshot
  //////////////////////

  // Zero-extended when Width is below ResultWidth
  always_ff @(posedge ACLK) begin
    if (snapStrobe) begin
      if (snapKind == SnapLap) begin
        result <= ResultWidth'(lapDelta);
      end else begin
        result <= ResultWidth'(count);
      end
    end
  end

  // The sequencer decodes one opcode per command
  property pClearNotWithSnap;
    @(posedge ACLK) disable iff (!ARESETN)
      !(countClear && snapStrobe);
  endproperty
  aClearNotWithSnap: assert property (pClearNotWithSnap)
    else $error("countClear and snapStrobe in the same cycle");

endmodule

// ==== returnSerializer.sv ====
`timescale 1ns/1ps

module returnSerializer import timerPkg::*; (
  input  logic                   ACLK,
  input  logic                   ARESETN,
  input  logic                   resultLoad,
  input  logic [ResultWidth-1:0] result,
  output logic                   retValid,
  input  logic                   retReady,
  output logic [31:0]            retData,
  output logic                   sendDone
);

  resultT held;       // Result being sent
  logic   highPhase;  // Low beat already accepted
  logic   beatAccept;

  assign beatAccept = retValid && retReady;
  assign sendDone   = beatAccept && highPhase;
  assign retData    = highPhase ? held.hi : held.lo;

  //////////////////////
  // Beat control
  //////////////////////

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      retValid  <= 1'b0;
      highPhase <= 1'b0;
    end else if (resultLoad) begin
      retValid  <= 1'b1;
      highPhase <= 1'b0;  // Low word first
    end else if (beatAccept) begin
      if (highPhase) begin
        retValid  <= 1'b0;
        highPhase <= 1'b0;
      end else begin
        highPhase <= 1'b1;
      end
    end
  end

  always_ff @(posedge ACLK) begin
    if (resultLoad) begin
      held <= result;
    end
  end

  //////////////////////
  // Assertions
  //////////////////////

  // Stalled beat keeps its data
  property pHoldWhileStalled;
    @(posedge ACLK) disable iff (!ARESETN)
      (retValid && !retReady) |=> (retValid && $stable(retData));
  endproperty
  aHoldWhileStalled: assert property (pHoldWhileStalled)
    else $error("retData changed while stalled");

  // A new result only after the previous one is fully sent
  property pNoLoadWhileBusy;
    @(posedge ACLK) disable iff (!ARESETN)
      resultLoad |-> !retValid;
  endproperty
  aNoLoadWhileBusy: assert property (pNoLoadWhileBusy)
    else $error("resultLoad while a result is in flight");

endmodule

// ==== cmdSequencer.sv ====
`timescale 1ns/1ps

module cmdSequencer import timerPkg::*; (
  input  logic     ACLK,
  input  logic     ARESETN,
  input  logic     cmdValid,
  output logic     cmdReady,
  input  cmdT      cmdData,
  output logic     countEnable,
  output logic     countClear,
  output logic     snapStrobe,
  output snapKindT snapKind,
  input  logic     sendDone
);

  seqStateT state;
  cmdT      cmdReg;     // Command latched in Fetch
  logic     enableReg;  // Running flag
  logic     isDecode;
  logic     startNow;
  logic     stopNow;

  //////////////////////
  // Decode
  //////////////////////

  assign isDecode = (state == Decode);
  assign cmdReady = (state == Fetch);

  assign startNow   = isDecode && (cmdReg.opcode == OpStart);
  assign stopNow    = isDecode && (cmdReg.opcode == OpStop);
  assign countClear = isDecode && (cmdReg.opcode == OpReset);
  assign snapStrobe = isDecode && ((cmdReg.opcode == OpRead) || (cmdReg.opcode == OpLap));
  assign snapKind   = (cmdReg.opcode == OpLap) ? SnapLap : SnapRead;

  // Start and Stop act on the counter at the edge leaving Decode
  assign countEnable = startNow || (enableReg && !stopNow);

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      enableReg <= 1'b0;
    end else if (startNow) begin
      enableReg <= 1'b1;
    end else if (stopNow) begin
      enableReg <= 1'b0;
    end
  end

  always_ff @(posedge ACLK) begin
    if (cmdValid && cmdReady) begin
      cmdReg <= cmdData;
    end
  end

  //////////////////////
  // FSM
  //////////////////////

  always_ff @(posedge ACLK) begin
    if (!ARESETN) begin
      state <= Fetch;
    end else begin
      case (state)
        Fetch: begin
          if (cmdValid) begin
            state <= Decode;
          end
        end
        Decode: begin
          if (snapStrobe) begin
            state <= SendWait;  // Wait for both beats
          end else begin
            state <= Fetch;     // Start, Stop, Reset and unknown opcodes
          end
        end
        SendWait: begin
          if (sendDone) begin
            state <= Fetch;
          end
        end
        default: begin
          state <= Fetch;
        end
      endcase
    end
  end

  //////////////////////
  // Assertions
  //////////////////////

  // Serializer only finishes a result that was asked for
  property pSendDoneInSendWait;
    @(posedge ACLK) disable iff (!ARESETN)
      sendDone |-> (state == SendWait);
  endproperty
  aSendDoneInSendWait: assert property (pSendDoneInSendWait)
    else $error("sendDone outside SendWait");

endmodule

// ==== stopwatchTop.sv ====
`timescale 1ns/1ps

module stopwatchTop import timerPkg::*; #(
  parameter int CountWidth = 64
) (
  input  logic        ACLK,
  input  logic        ARESETN,
  input  logic        cmdValid,
  output logic        cmdReady,
  input  cmdT         cmdData,
  output logic        retValid,
  input  logic        retReady,
  output logic [31:0] retData
);

  logic                   countEnable;
  logic                   countClear;
  logic [CountWidth-1:0]  count;
  logic                   snapStrobe;
  snapKindT               snapKind;
  logic                   resultLoad;
  logic [ResultWidth-1:0] result;
  logic                   sendDone;

  cmdSequencer uSequencer (
    .ACLK        (ACLK),
    .ARESETN     (ARESETN),
    .cmdValid    (cmdValid),
    .cmdReady    (cmdReady),
    .cmdData     (cmdData),
    .countEnable (countEnable),
    .countClear  (countClear),
    .snapStrobe  (snapStrobe),
    .snapKind    (snapKind),
    .sendDone    (sendDone)
  );

  tickCounter #(.Width(CountWidth)) uCounter (
    .ACLK        (ACLK),
    .ARESETN     (ARESETN),
    .countEnable (countEnable),
    .countClear  (countClear),
    .count       (count)
  );

  lapRecorder #(.Width(CountWidth)) uLap (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .count      (count),
    .countClear (countClear),
    .snapStrobe (snapStrobe),
    .snapKind   (snapKind),
    .resultLoad (resultLoad),
    .result     (result)
  );

  returnSerializer uSerializer (
    .ACLK       (ACLK),
    .ARESETN    (ARESETN),
    .resultLoad (resultLoad),
    .result     (result),
    .retValid   (retValid),
    .retReady   (retReady),
    .retData    (retData),
    .sendDone   (sendDone)
  );

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
  parameter int HalfPeriod  = 20,
  parameter int ResetCycles = 5
) (
  output logic ACLK,
  output logic ARESETN
);

  initial begin
    ACLK = 1'b0;
    forever #(HalfPeriod) ACLK = ~ACLK;  // 40 ns period
  end

  initial begin
    ARESETN = 1'b0;
    repeat (ResetCycles) @(posedge ACLK);
    ARESETN <= 1'b1;  // Released on a rising edge
  end

endmodule

// ==== stopwatchTb.sv ====
`timescale 1ns/1ps

module stopwatchTb import timerPkg::*; ();

  localparam int TimeoutCycles = 200;

  logic            ACLK;
  logic            ARESETN;
  logic            cmdValid;
  logic            cmdReady;
  cmdT             cmdData;
  logic            retValid;
  logic            retReady;
  logic [31:0]     retData;

  integer          seed = 32'h79be_a3c4;
  int              checkErrors = 0;
  int              protocolErrors = 0;
  int              timeouts = 0;
  longint unsigned cycle = 0;  // Rising edges seen so far

  tbClock uClock (
    .ACLK    (ACLK),
    .ARESETN (ARESETN)
  );

  stopwatchTop #(.CountWidth(64)) DUT (
    .ACLK     (ACLK),
    .ARESETN  (ARESETN),
    .cmdValid (cmdValid),
    .cmdReady (cmdReady),
    .cmdData  (cmdData),
    .retValid (retValid),
    .retReady (retReady),
    .retData  (retData)
  );

  always @(posedge ACLK) begin
    cycle <= cycle + 1;
  end

  ////////////////////
  // Stream rules
  ////////////////////

  aStallHold: assert property (@(posedge ACLK) disable iff (!ARESETN)
      (retValid && !retReady) |=> (retValid && $stable(retData)))
    else begin
      protocolErrors++;
      $display("error @%0t: return beat dropped or changed while stalled", $time);
    end

  aBusyNoCommand: assert property (@(posedge ACLK) disable iff (!ARESETN)
      retValid |-> !cmdReady)
    else begin
      protocolErrors++;
      $display("error @%0t: cmdReady high while a result is in flight", $time);
    end

  ////////////////////
  // Checks
  ////////////////////

  task automatic expectEqual(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else begin
        checkErrors++;
        $display("error @%0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
  endtask

  task automatic expectTrue(input string what, input bit cond);
    assert (cond)
      else begin
        checkErrors++;
        $display("error @%0t: %s", $time, what);
      end
  endtask

  ////////////////////
  // Stream drivers
  ////////////////////

  // acceptCycle is the edge count just before the accepting edge
  task automatic sendCommand(input logic [15:0] op, input logic [15:0] arg,
                             output longint unsigned acceptCycle);
    cmdT cmd;
    int  waited;
    cmd.opcode = opcodeT'(op);
    cmd.arg    = arg;
    waited     = 0;
    @(posedge ACLK);
    cmdValid <= 1'b1;
    cmdData  <= cmd;
    @(negedge ACLK);
    while (!cmdReady && waited < TimeoutCycles) begin
      @(negedge ACLK);
      waited++;
    end
    if (!cmdReady) begin
      timeouts++;
      $display("Timed out waiting for the DUT to accept opcode %0d", op);
    end
    acceptCycle = cycle;
    @(posedge ACLK);
    cmdValid <= 1'b0;
  endtask

  task automatic collectResult(output logic [63:0] value);
    int beat;
    int waited;
    int r;
    beat   = 0;
    waited = 0;
    value  = '0;
    while (beat < 2 && waited < TimeoutCycles) begin
      @(posedge ACLK);
      r = $random(seed);
      retReady <= r[0];  // Random back-pressure
      @(negedge ACLK);
      if (retValid && retReady) begin
        if (beat == 0) begin
          value[31:0] = retData;   // Low word comes first
        end else begin
          value[63:32] = retData;
        end
        beat++;
      end
      waited++;
    end
    if (beat < 2) begin
      timeouts++;
      $display("Timed out waiting for a result, got %0d of 2 beats", beat);
    end
    @(posedge ACLK);
    retReady <= 1'b0;
  endtask

  task automatic requestResult(input logic [15:0] op, input logic [15:0] arg,
                               output logic [63:0] value,
                               output longint unsigned acceptCycle);
    sendCommand(op, arg, acceptCycle);
    collectResult(value);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    logic [63:0]     value;
    logic [63:0]     prev;
    logic [63:0]     lap;
    logic [63:0]     stopped;
    longint unsigned startAt;
    longint unsigned stopAt;
    longint unsigned readAt;
    longint unsigned lapAt;
    longint unsigned unusedAt;
    int              waited;
    int              r;
    cmdValid = 1'b0;
    cmdData  = '0;
    retReady = 1'b0;

    waited = 0;
    while (!ARESETN && waited < TimeoutCycles) begin
      @(posedge ACLK);
      waited++;
    end
    if (!ARESETN) begin
      timeouts++;
      $display("Timed out waiting for reset release");
    end
    @(negedge ACLK);

    // After reset
    expectTrue("retValid high after reset", !retValid);
    expectTrue("cmdReady low after reset", cmdReady);
    requestResult(OpRead, 16'h0, value, unusedAt);
    expectEqual("Read after reset", value, 64'd0);

    // Run for a random time, then stop
    sendCommand(OpStart, 16'h0, startAt);
    r = $random(seed);
    repeat (10 + (r & 63)) @(posedge ACLK);
    sendCommand(OpStop, 16'h0, stopAt);
    stopped = stopAt - startAt;  // One tick per edge between the two decodes
    requestResult(OpRead, 16'h0, value, unusedAt);
    expectEqual("first Read after Stop", value, stopped);
    expectEqual("high word of Read", 64'(value[63:32]), 64'd0);
    requestResult(OpRead, 16'h0, value, unusedAt);
    expectEqual("second Read after Stop", value, stopped);
    expectTrue("stopped count is zero", value != 64'd0);

    // Laps on a stopped count
    requestResult(OpLap, 16'h0, lap, unusedAt);
    expectEqual("first Lap", lap, stopped);
    requestResult(OpLap, 16'h0, lap, unusedAt);
    expectEqual("second Lap", lap, 64'd0);
    requestResult(OpRead, 16'h0, value, unusedAt);
    expectEqual("Read after Laps", value, stopped);

    // Reset, then a running count
    sendCommand(OpReset, 16'h0, unusedAt);
    requestResult(OpRead, 16'h0, value, unusedAt);
    expectEqual("Read after Reset", value, 64'd0);
    sendCommand(OpStart, 16'h0, startAt);
    prev = '0;
    for (int i = 0; i < 5; i++) begin
      requestResult(OpRead, 16'h0, value, readAt);
      expectEqual("running Read", value, readAt - startAt);
      expectTrue("running Reads not increasing", value > prev);
      prev = value;
    end
    requestResult(OpLap, 16'h0, lap, lapAt);
    expectEqual("Lap while running", lap, lapAt - startAt);  // Mark cleared by Reset
    requestResult(OpRead, 16'h0, value, readAt);
    expectTrue("Lap larger than the next Read", lap <= value);

    // Unknown opcodes leave a stopped count alone
    sendCommand(OpStop, 16'h0, stopAt);
    requestResult(OpRead, 16'h0, stopped, unusedAt);
    expectEqual("Read after second Stop", stopped, stopAt - startAt);
    sendCommand(16'h0000, 16'h0, unusedAt);
    sendCommand(16'h0007, 16'h5a5a, unusedAt);
    sendCommand(16'hffff, 16'hffff, unusedAt);
    requestResult(OpRead, 16'hbeef, value, unusedAt);  // Lower half ignored
    expectEqual("Read after unknown opcodes", value, stopped);

    repeat (2) @(posedge ACLK);
    $display("Errors: %0d check, %0d protocol, %0d timeout",
             checkErrors, protocolErrors, timeouts);
    if (checkErrors + protocolErrors + timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
timerPkg.sv
tickCounter.sv
lapRecorder.sv
returnSerializer.sv
cmdSequencer.sv
stopwatchTop.sv
tbClock.sv
stopwatchTb.sv

// ==== Makefile ====
# Verilator build and run for the stopwatch testbench

TOP = stopwatchTb
OBJ = obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -Mdir $(OBJ) -f files.f

run: build
	./$(OBJ)/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failures found" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" sim.log; then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f files.f

clean:
	rm -rf $(OBJ) sim.log
